//--- Bender.yml
package:
  name: mpt_decode

sources:
  - files:
      - mpt_pkg.sv
      - mpt_frame_ctrl.sv
      - mpt_header_parse.sv
      - mpt_lane_accum.sv
      - mpt_decode_top.sv
  - target: simulation
    files:
      - tb_mpt_decode.sv

//--- mpt_decode_top.sv
//####################
// mapping-table decoder top, controller, header parser
// and four sum lanes
//####################
`timescale 1ns/1ps
module mpt_decode_top #(
  parameter int VID_HACT = 1288,
  parameter int VID_VACT = 720
) (
  input  logic                          mpt_clk,
  input  logic                          mpt_arst,
  input  logic                          frame_start,
  input  logic                          word_valid,
  input  logic [mpt_pkg::WORD_W-1:0]    word,
  input  logic                          line_ack,
  output logic                          check_ok,
  output logic [7:0]                    x_num,
  output logic [7:0]                    y_num,
  output logic [15:0]                   oneline_y_max,
  output logic [mpt_pkg::INT_W-1:0]     lx_int,
  output logic [mpt_pkg::INT_W-1:0]     ly_int,
  output logic [mpt_pkg::INT_W-1:0]     rx_int,
  output logic [mpt_pkg::INT_W-1:0]     ry_int,
  output logic [mpt_pkg::FRAC_W-1:0]    lx_frac,
  output logic [mpt_pkg::FRAC_W-1:0]    ly_frac,
  output logic [mpt_pkg::FRAC_W-1:0]    rx_frac,
  output logic [mpt_pkg::FRAC_W-1:0]    ry_frac,
  output logic                          out_vld,
  output logic                          line_rdy
);

  localparam int NW = mpt_pkg::NIBBLE_W;

  logic                         hdr_valid;
  logic [2:0]                   hdr_idx;
  logic                         seed;
  logic                         acc;
  logic [mpt_pkg::LEVEL_W-1:0]  x_level;
  logic [mpt_pkg::LEVEL_W-1:0]  y_level;
  logic                         x_sign;
  logic                         y_sign;
  mpt_pkg::scale_e              x_scale;
  mpt_pkg::scale_e              y_scale;
  logic [NW-1:0]                lx_nib;
  logic [NW-1:0]                ly_nib;
  logic [NW-1:0]                rx_nib;
  logic [NW-1:0]                ry_nib;

  // fields high to low
  assign lx_nib = word[4*NW-1:3*NW];
  assign ly_nib = word[3*NW-1:2*NW];
  assign rx_nib = word[2*NW-1:NW];
  assign ry_nib = word[NW-1:0];

  mpt_frame_ctrl #(
    .VID_HACT (VID_HACT),
    .VID_VACT (VID_VACT)
  ) i_frame_ctrl (
    .mpt_clk     (mpt_clk),
    .mpt_arst    (mpt_arst),
    .frame_start (frame_start),
    .word_valid  (word_valid),
    .line_ack    (line_ack),
    .hdr_valid   (hdr_valid),
    .hdr_idx     (hdr_idx),
    .seed        (seed),
    .acc         (acc),
    .out_vld     (out_vld),
    .line_rdy    (line_rdy)
  );

  mpt_header_parse i_header_parse (
    .mpt_clk       (mpt_clk),
    .mpt_arst      (mpt_arst),
    .frame_start   (frame_start),
    .hdr_valid     (hdr_valid),
    .hdr_idx       (hdr_idx),
    .word          (word),
    .check_ok      (check_ok),
    .x_num         (x_num),
    .y_num         (y_num),
    .x_level       (x_level),
    .y_level       (y_level),
    .x_sign        (x_sign),
    .y_sign        (y_sign),
    .oneline_y_max (oneline_y_max),
    .x_scale       (x_scale),
    .y_scale       (y_scale)
  );

  mpt_lane_accum i_lane_lx (
    .mpt_clk    (mpt_clk),
    .mpt_arst   (mpt_arst),
    .seed       (seed),
    .acc        (acc),
    .nibble     (lx_nib),
    .level      (x_level),
    .level_sign (x_sign),
    .scale      (x_scale),
    .sum_int    (lx_int),
    .sum_frac   (lx_frac)
  );

  mpt_lane_accum i_lane_ly (
    .mpt_clk    (mpt_clk),
    .mpt_arst   (mpt_arst),
    .seed       (seed),
    .acc        (acc),
    .nibble     (ly_nib),
    .level      (y_level),
    .level_sign (y_sign),
    .scale      (y_scale),
    .sum_int    (ly_int),
    .sum_frac   (ly_frac)
  );

  mpt_lane_accum i_lane_rx (
    .mpt_clk    (mpt_clk),
    .mpt_arst   (mpt_arst),
    .seed       (seed),
    .acc        (acc),
    .nibble     (rx_nib),
    .level      (x_level),
    .level_sign (x_sign),
    .scale      (x_scale),
    .sum_int    (rx_int),
    .sum_frac   (rx_frac)
  );

  mpt_lane_accum i_lane_ry (
    .mpt_clk    (mpt_clk),
    .mpt_arst   (mpt_arst),
    .seed       (seed),
    .acc        (acc),
    .nibble     (ry_nib),
    .level      (y_level),
    .level_sign (y_sign),
    .scale      (y_scale),
    .sum_int    (ry_int),
    .sum_frac   (ry_frac)
  );

endmodule

//--- mpt_frame_ctrl.sv
//####################
// frame controller: header and pixel word counting,
// lane strobes, output valid and line ready
//####################
`timescale 1ns/1ps
module mpt_frame_ctrl #(
  parameter int VID_HACT = 1288,
  parameter int VID_VACT = 720
) (
  input  logic       mpt_clk,
  input  logic       mpt_arst,
  input  logic       frame_start,
  input  logic       word_valid,
  input  logic       line_ack,
  output logic       hdr_valid,
  output logic [2:0] hdr_idx,
  output logic       seed,
  output logic       acc,
  output logic       out_vld,
  output logic       line_rdy
);

  localparam int X_W = $clog2(VID_HACT + 1);
  localparam int Y_W = $clog2(VID_VACT + 1);

  mpt_pkg::frame_state_e state;

  logic [2:0]     hdr_cnt;
  logic [X_W-1:0] x_idx;   // word index inside the line
  logic [Y_W-1:0] y_cnt;   // finished lines
  logic           pix_word;
  logic           line_end;
  logic           vld_set;
  logic           vld_d1;

  // a word on the frame start edge belongs to no frame
  assign hdr_valid = word_valid && !frame_start && (state == mpt_pkg::ST_HEADER);
  assign hdr_idx   = hdr_cnt;
  assign pix_word  = word_valid && !frame_start && (state == mpt_pkg::ST_PIXEL);

  assign seed     = pix_word && (x_idx < X_W'(mpt_pkg::SEED_WORDS));
  assign acc      = pix_word && (x_idx >= X_W'(mpt_pkg::SEED_WORDS));
  assign line_end = pix_word && (x_idx == X_W'(VID_HACT - 1));
  assign vld_set  = pix_word && (x_idx >= X_W'(mpt_pkg::SEED_WORDS - 1)); // last seed onward

  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      state   <= mpt_pkg::ST_IDLE;
      hdr_cnt <= '0;
      x_idx   <= '0;
      y_cnt   <= '0;
    end else if (frame_start) begin
      state   <= mpt_pkg::ST_HEADER;
      hdr_cnt <= '0;
      x_idx   <= '0;
      y_cnt   <= '0;
    end else begin
      case (state)
        mpt_pkg::ST_HEADER: begin
          if (hdr_valid) begin
            hdr_cnt <= hdr_cnt + 3'd1;
            if (hdr_cnt == 3'(mpt_pkg::HEADER_WORDS - 1)) begin
              state <= mpt_pkg::ST_PIXEL;
            end
          end
        end
        mpt_pkg::ST_PIXEL: begin
          if (line_end) begin
            x_idx <= '0;
            y_cnt <= y_cnt + 1'b1;
            if (y_cnt == Y_W'(VID_VACT - 1)) begin
              state <= mpt_pkg::ST_DONE; // frame complete
            end
          end else if (pix_word) begin
            x_idx <= x_idx + 1'b1;
          end
        end
        default: begin
          state <= state; // idle and done wait for frame start
        end
      endcase
    end
  end

  // two stages, sum update then scaling in the lanes
  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      vld_d1  <= 1'b0;
      out_vld <= 1'b0;
    end else begin
      vld_d1  <= vld_set;
      out_vld <= vld_d1;
    end
  end

  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      line_rdy <= 1'b0;
    end else if (frame_start || line_ack) begin
      line_rdy <= 1'b0; // clear beats set
    end else if (line_end) begin
      line_rdy <= 1'b1;
    end
  end

  a_seed_acc_excl : assert property (
    @(posedge mpt_clk) disable iff (mpt_arst)
    !(seed && acc)
  );

  // no output may come from a word seen after the last line
  a_no_vld_done : assert property (
    @(posedge mpt_clk) disable iff (mpt_arst)
    out_vld |-> ($past(state, 2) != mpt_pkg::ST_DONE)
  );

endmodule

//--- mpt_header_parse.sv
//####################
// header parser: sync word check, grid counts, offsets,
// line maximum and scale choice
//####################
`timescale 1ns/1ps
module mpt_header_parse (
  input  logic                            mpt_clk,
  input  logic                            mpt_arst,
  input  logic                            frame_start,
  input  logic                            hdr_valid,
  input  logic [2:0]                      hdr_idx,
  input  logic [mpt_pkg::WORD_W-1:0]      word,
  output logic                            check_ok,
  output logic [7:0]                      x_num,
  output logic [7:0]                      y_num,
  output logic [mpt_pkg::LEVEL_W-1:0]     x_level,
  output logic [mpt_pkg::LEVEL_W-1:0]     y_level,
  output logic                            x_sign,
  output logic                            y_sign,
  output logic [15:0]                     oneline_y_max,
  output mpt_pkg::scale_e                 x_scale,
  output mpt_pkg::scale_e                 y_scale
);

  logic [2:0]                 sync_cnt; // sync words matched in order
  logic [mpt_pkg::WORD_W-1:0] sync_exp;
  logic                       sync_hit;

  assign sync_exp = (hdr_idx < 3'd2) ? mpt_pkg::SYNC_WORD_A : mpt_pkg::SYNC_WORD_B;
  assign sync_hit = hdr_valid && (hdr_idx < 3'd4) && (word == sync_exp)
                    && (sync_cnt == hdr_idx);

  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      sync_cnt <= '0;
      check_ok <= 1'b0;
    end else if (frame_start) begin
      sync_cnt <= '0;
      check_ok <= 1'b0;
    end else begin
      if (sync_hit) begin
        sync_cnt <= sync_cnt + 3'd1;
      end
      check_ok <= (sync_cnt == 3'd4);
    end
  end

  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      x_num         <= 8'd0;
      y_num         <= 8'd0;
      x_level       <= '0;
      y_level       <= '0;
      x_sign        <= 1'b0;
      y_sign        <= 1'b0;
      oneline_y_max <= 16'd400;
    end else if (hdr_valid) begin
      case (hdr_idx)
        3'd5: begin
          x_num <= word[7:0];
          y_num <= word[15:8];
        end
        3'd6: begin
          x_sign  <= word[7];   // 1 adds the offset
          x_level <= word[6:0];
          y_sign  <= word[15];
          y_level <= word[14:8];
        end
        3'd7: oneline_y_max <= word;
        default: begin
          x_num <= x_num; // sync and reserved words
        end
      endcase
    end
  end

  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      x_scale <= mpt_pkg::SCALE_64;
      y_scale <= mpt_pkg::SCALE_64;
    end else begin
      x_scale <= mpt_pkg::scale_from_count(x_num);
      y_scale <= mpt_pkg::scale_from_count(y_num);
    end
  end

  a_scale_legal : assert property (
    @(posedge mpt_clk) disable iff (mpt_arst)
    (x_scale inside {mpt_pkg::SCALE_16, mpt_pkg::SCALE_32, mpt_pkg::SCALE_64}) &&
    (y_scale inside {mpt_pkg::SCALE_16, mpt_pkg::SCALE_32, mpt_pkg::SCALE_64})
  );

endmodule

//--- mpt_lane_accum.sv
//####################
// one running-sum lane: seed window, offset accumulation,
// integer and fraction split
//####################
`timescale 1ns/1ps
module mpt_lane_accum (
  input  logic                          mpt_clk,
  input  logic                          mpt_arst,
  input  logic                          seed,
  input  logic                          acc,
  input  logic [mpt_pkg::NIBBLE_W-1:0]  nibble,
  input  logic [mpt_pkg::LEVEL_W-1:0]   level,
  input  logic                          level_sign,
  input  mpt_pkg::scale_e               scale,
  output logic [mpt_pkg::INT_W-1:0]     sum_int,
  output logic [mpt_pkg::FRAC_W-1:0]    sum_frac
);

  localparam int WIN_W = mpt_pkg::SEED_WORDS * mpt_pkg::NIBBLE_W;
  localparam int SUM_W = mpt_pkg::SUM_W;

  logic [SUM_W-1:0] sum;
  logic [SUM_W-1:0] nib_ext;
  logic [SUM_W-1:0] lvl_ext;
  logic [SUM_W-1:0] acc_base;
  logic [2:0]       shift;

  assign nib_ext  = SUM_W'(nibble);
  assign lvl_ext  = SUM_W'(level);
  assign acc_base = sum + nib_ext;
  assign shift    = mpt_pkg::scale_shift(scale);

  always_ff @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst) begin
      sum <= '0;
    end else if (seed) begin
      // newest nibble enters at the top, first word ends in the low nibble
      sum <= {{(SUM_W - WIN_W){1'b0}}, nibble, sum[WIN_W-1:mpt_pkg::NIBBLE_W]};
    end else if (acc) begin
      if (level_sign) begin
        sum <= acc_base + lvl_ext;
      end else begin
        sum <= acc_base - lvl_ext; // wraps modulo 2**SUM_W
      end
    end
  end

  always_ff @(posedge mpt_clk) begin
    sum_int  <= mpt_pkg::INT_W'(sum >> shift);
    sum_frac <= sum[mpt_pkg::FRAC_W-1:0] & ~({mpt_pkg::FRAC_W{1'b1}} << shift);
  end

endmodule

//--- mpt_pkg.sv
//####################
// mapping-table decoder shared widths, header constants,
// state and scale enums
//####################
package mpt_pkg;

  // stream and header layout
  localparam int HEADER_WORDS = 8;
  localparam int WORD_W       = 16;
  localparam int NIBBLE_W     = 4;
  localparam int SEED_WORDS   = 4;

  localparam logic [WORD_W-1:0] SYNC_WORD_A = 16'haaaa; // header words 0 and 1
  localparam logic [WORD_W-1:0] SYNC_WORD_B = 16'h5555; // header words 2 and 3

  // lane arithmetic
  localparam int LEVEL_W = 7;
  localparam int SUM_W   = 18;
  localparam int INT_W   = 11;
  localparam int FRAC_W  = 6;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_HEADER = 2'd1,
    ST_PIXEL  = 2'd2,
    ST_DONE   = 2'd3
  } frame_state_e;

  typedef enum logic [1:0] {
    SCALE_16 = 2'd0,
    SCALE_32 = 2'd1,
    SCALE_64 = 2'd2
  } scale_e;

  // grid count to shift choice, anything unknown scales as 64
  function automatic scale_e scale_from_count(input logic [7:0] count);
    case (count)
      8'd16:   return SCALE_16;
      8'd32:   return SCALE_32;
      default: return SCALE_64;
    endcase
  endfunction

  function automatic logic [2:0] scale_shift(input scale_e scale);
    case (scale)
      SCALE_16: return 3'd4;
      SCALE_32: return 3'd5;
      default:  return 3'd6;
    endcase
  endfunction

endpackage

//--- sim.f
mpt_pkg.sv
mpt_frame_ctrl.sv
mpt_header_parse.sv
mpt_lane_accum.sv
mpt_decode_top.sv
tb_mpt_decode.sv

//--- tb_mpt_decode.sv
//####################
// testbench for the mapping-table decoder with random
// frames against a reference model
//####################
`timescale 1ns/1ps
module tb_mpt_decode;

  localparam int VID_HACT   = 12;
  localparam int VID_VACT   = 3;
  localparam int CLK_PERIOD = 40;
  localparam int SUM_W      = mpt_pkg::SUM_W;
  localparam int INT_W      = mpt_pkg::INT_W;
  localparam int FRAC_W     = mpt_pkg::FRAC_W;
  localparam int FRAME_WORDS = 8 + VID_HACT * VID_VACT;
  localparam int MAX_CYCLES  = 4 * (FRAME_WORDS + 20) * 3; // four frames with gaps and margin

  localparam logic [1:0] KIND_NONE = 2'd0;
  localparam logic [1:0] KIND_HDR  = 2'd1;
  localparam logic [1:0] KIND_PIX  = 2'd2;

  logic              mpt_clk;
  logic              mpt_arst;
  logic              frame_start;
  logic              word_valid;
  logic [15:0]       word;
  logic              line_ack;
  logic              check_ok;
  logic [7:0]        x_num;
  logic [7:0]        y_num;
  logic [15:0]       oneline_y_max;
  logic [INT_W-1:0]  dut_int [4];  // lx, ly, rx, ry
  logic [FRAC_W-1:0] dut_frac [4];
  logic              out_vld;
  logic              line_rdy;

  integer            seed = 32'hc3400011;
  int                cycle_cnt = 0;
  int                vld_count;
  logic [1:0]        tag_kind; // what the driven word is
  int                tag_idx;

  // reference model state
  logic [SUM_W-1:0]  m_sum [4];
  logic [INT_W-1:0]  exp1_int [4];
  logic [INT_W-1:0]  exp2_int [4];
  logic [FRAC_W-1:0] exp1_frac [4];
  logic [FRAC_W-1:0] exp2_frac [4];
  logic              exp1_vld;
  logic              exp2_vld;
  logic              m_rdy;
  logic              m_check;
  logic              sync_good;
  logic              sync_pend;
  logic [7:0]        m_xnum;
  logic [7:0]        m_ynum;
  logic [15:0]       m_ymax;
  logic [6:0]        m_xlvl;
  logic [6:0]        m_ylvl;
  logic              m_xsgn;
  logic              m_ysgn;

  mpt_decode_top #(
    .VID_HACT (VID_HACT),
    .VID_VACT (VID_VACT)
  ) i_dut (
    .mpt_clk       (mpt_clk),
    .mpt_arst      (mpt_arst),
    .frame_start   (frame_start),
    .word_valid    (word_valid),
    .word          (word),
    .line_ack      (line_ack),
    .check_ok      (check_ok),
    .x_num         (x_num),
    .y_num         (y_num),
    .oneline_y_max (oneline_y_max),
    .lx_int        (dut_int[0]),
    .ly_int        (dut_int[1]),
    .rx_int        (dut_int[2]),
    .ry_int        (dut_int[3]),
    .lx_frac       (dut_frac[0]),
    .ly_frac       (dut_frac[1]),
    .rx_frac       (dut_frac[2]),
    .ry_frac       (dut_frac[3]),
    .out_vld       (out_vld),
    .line_rdy      (line_rdy)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    stop_on_error($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic string lane_name(input int lane);
    case (lane)
      0:       return "lx";
      1:       return "ly";
      2:       return "rx";
      default: return "ry";
    endcase
  endfunction

  // 16 -> 4, 32 -> 5, anything else -> 6
  function automatic int shift_for(input logic [7:0] count);
    if (count == 8'd16) return 4;
    if (count == 8'd32) return 5;
    return 6;
  endfunction

  function automatic logic [SUM_W-1:0] lane_next(input logic [SUM_W-1:0] sum,
      input logic [3:0] nib, input logic [6:0] lvl, input logic sgn, input int idx);
    logic [SUM_W-1:0] seeded;
    seeded = SUM_W'(sum[15:0] >> 4) | (SUM_W'(nib) << 12);
    if (idx < 4) return seeded;
    if (sgn) return sum + nib + lvl;
    return sum + nib - lvl;
  endfunction

  function automatic logic [INT_W-1:0] int_part(input logic [SUM_W-1:0] sum,
                                                input logic [7:0] count);
    return INT_W'(sum >> shift_for(count));
  endfunction

  function automatic logic [FRAC_W-1:0] frac_part(input logic [SUM_W-1:0] sum,
                                                  input logic [7:0] count);
    logic [SUM_W-1:0] mask;
    mask = (SUM_W'(1) << shift_for(count)) - 1'b1;
    return FRAC_W'(sum & mask);
  endfunction

  always @(posedge mpt_clk or posedge mpt_arst) begin : ref_model
    logic [SUM_W-1:0] nxt;
    logic [7:0]       cnt;
    if (mpt_arst) begin
      m_check   <= 1'b0;
      sync_good <= 1'b1;
      sync_pend <= 1'b0;
      m_rdy     <= 1'b0;
      m_xnum    <= 8'd0;
      m_ynum    <= 8'd0;
      m_ymax    <= 16'd400;
      {m_ysgn, m_ylvl, m_xsgn, m_xlvl} <= 16'd0;
      exp1_vld  <= 1'b0;
      exp2_vld  <= 1'b0;
      for (int l = 0; l < 4; l++) begin
        m_sum[l] <= '0;
      end
    end else begin
      sync_pend <= 1'b0;
      if (frame_start) begin
        m_check   <= 1'b0;
        sync_good <= 1'b1;
        m_rdy     <= 1'b0;
      end else begin
        if (sync_pend) m_check <= sync_good;
        if (line_ack) m_rdy <= 1'b0; // clear wins
        else if (tag_kind == KIND_PIX && tag_idx == VID_HACT - 1) m_rdy <= 1'b1;
      end
      if (tag_kind == KIND_HDR) begin
        case (tag_idx)
          0, 1: sync_good <= sync_good && (word == 16'haaaa);
          2:    sync_good <= sync_good && (word == 16'h5555);
          3: begin
            sync_good <= sync_good && (word == 16'h5555);
            sync_pend <= 1'b1;
          end
          5:       {m_ynum, m_xnum} <= word;
          6:       {m_ysgn, m_ylvl, m_xsgn, m_xlvl} <= word;
          7:       m_ymax <= word;
          default: m_ymax <= m_ymax;
        endcase
      end
      for (int l = 0; l < 4; l++) begin
        nxt = m_sum[l];
        if (tag_kind == KIND_PIX && l % 2 == 0) begin
          nxt = lane_next(m_sum[l], word[15-4*l -: 4], m_xlvl, m_xsgn, tag_idx);
        end else if (tag_kind == KIND_PIX) begin
          nxt = lane_next(m_sum[l], word[15-4*l -: 4], m_ylvl, m_ysgn, tag_idx);
        end
        cnt = (l % 2 == 0) ? m_xnum : m_ynum;
        m_sum[l]     <= nxt;
        exp1_int[l]  <= int_part(nxt, cnt);
        exp1_frac[l] <= frac_part(nxt, cnt);
        exp2_int[l]  <= exp1_int[l];
        exp2_frac[l] <= exp1_frac[l];
      end
      exp1_vld <= (tag_kind == KIND_PIX) && (tag_idx >= 3);
      exp2_vld <= exp1_vld;
    end
  end

  always @(posedge mpt_clk or posedge mpt_arst) begin
    if (mpt_arst || frame_start) vld_count <= 0;
    else if (out_vld) vld_count <= vld_count + 1;
  end

  a_out_vld : assert property (@(posedge mpt_clk) disable iff (mpt_arst) out_vld == exp2_vld)
    else value_error("out_vld", $sampled(out_vld), $sampled(exp2_vld));
  a_line_rdy : assert property (@(posedge mpt_clk) disable iff (mpt_arst) line_rdy == m_rdy)
    else value_error("line_rdy", $sampled(line_rdy), $sampled(m_rdy));
  a_check_ok : assert property (@(posedge mpt_clk) disable iff (mpt_arst) check_ok == m_check)
    else value_error("check_ok", $sampled(check_ok), $sampled(m_check));
  a_x_num : assert property (@(posedge mpt_clk) disable iff (mpt_arst) x_num == m_xnum)
    else value_error("x_num", $sampled(x_num), $sampled(m_xnum));
  a_y_num : assert property (@(posedge mpt_clk) disable iff (mpt_arst) y_num == m_ynum)
    else value_error("y_num", $sampled(y_num), $sampled(m_ynum));
  a_y_max : assert property (@(posedge mpt_clk) disable iff (mpt_arst) oneline_y_max == m_ymax)
    else value_error("oneline_y_max", $sampled(oneline_y_max), $sampled(m_ymax));

  for (genvar g = 0; g < 4; g++) begin : g_lane_chk
    a_int : assert property (@(posedge mpt_clk) disable iff (mpt_arst)
      out_vld |-> dut_int[g] == exp2_int[g])
      else value_error({lane_name(g), "_int"}, $sampled(dut_int[g]), $sampled(exp2_int[g]));
    a_frac : assert property (@(posedge mpt_clk) disable iff (mpt_arst)
      out_vld |-> dut_frac[g] == exp2_frac[g])
      else value_error({lane_name(g), "_frac"}, $sampled(dut_frac[g]), $sampled(exp2_frac[g]));
  end

  always @(posedge mpt_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) stop_on_error("timeout, run did not end within the cycle limit");
  end

  task automatic drive_cycle(input logic vld, input logic [15:0] w, input logic [1:0] kind,
                             input int idx, input logic ack);
    @(negedge mpt_clk);
    frame_start = 1'b0;
    word_valid  = vld;
    word        = w;
    tag_kind    = kind;
    tag_idx     = idx;
    line_ack    = ack;
  endtask

  task automatic random_gap();
    if ($random(seed) & 1) drive_cycle(1'b0, 16'($random(seed)), KIND_NONE, 0, 1'b0);
  endtask

  task automatic run_frame(input logic [7:0] xn, input logic [7:0] yn, input logic xs,
                           input logic ys, input int bad_sync, input logic ack_clash);
    logic [15:0] hdr [8];
    logic        ack;
    @(negedge mpt_clk);
    frame_start = 1'b1;
    word_valid  = 1'b0;
    line_ack    = 1'b0;
    tag_kind    = KIND_NONE;
    hdr[0] = 16'haaaa;
    hdr[1] = 16'haaaa;
    hdr[2] = 16'h5555;
    hdr[3] = 16'h5555;
    hdr[4] = 16'($random(seed));
    hdr[5] = {yn, xn};
    hdr[6] = {ys, 7'($random(seed)), xs, 7'($random(seed))};
    hdr[7] = 16'($random(seed));
    if (bad_sync >= 0) hdr[bad_sync] = hdr[bad_sync] ^ 16'h0100;
    for (int k = 0; k < 8; k++) begin
      drive_cycle(1'b1, hdr[k], KIND_HDR, k, 1'b0);
      random_gap();
    end
    for (int ln = 0; ln < VID_VACT; ln++) begin
      for (int x = 0; x < VID_HACT; x++) begin
        ack = (x == 5) || (ack_clash && ln == 1 && x == VID_HACT - 1);
        drive_cycle(1'b1, 16'($random(seed)), KIND_PIX, x, ack);
        random_gap();
      end
    end
    while (!line_rdy) drive_cycle(1'b0, 16'd0, KIND_NONE, 0, 1'b0);
    drive_cycle(1'b0, 16'd0, KIND_NONE, 0, bad_sync < 0); // bad frame keeps line ready set
    repeat (4) drive_cycle(1'b1, 16'($random(seed)), KIND_NONE, 0, 1'b0); // after last line
    drive_cycle(1'b0, 16'd0, KIND_NONE, 0, 1'b0);
    assert (vld_count == VID_VACT * (VID_HACT - 3))
      else value_error("out_vld count", vld_count, VID_VACT * (VID_HACT - 3));
    assert (check_ok == (bad_sync < 0)) else value_error("check_ok", check_ok, bad_sync < 0);
    assert (x_num == xn) else value_error("x_num", x_num, xn);
    assert (y_num == yn) else value_error("y_num", y_num, yn);
  endtask

  initial begin
    mpt_clk = 1'b0;
    forever #(CLK_PERIOD / 2) mpt_clk = ~mpt_clk;
  end

  initial begin
    mpt_arst    = 1'b1;
    frame_start = 1'b0;
    word_valid  = 1'b0;
    word        = 16'd0;
    line_ack    = 1'b0;
    tag_kind    = KIND_NONE;
    tag_idx     = 0;
    repeat (4) @(posedge mpt_clk);
    @(negedge mpt_clk);
    mpt_arst = 1'b0;
    run_frame(8'd16, 8'd32, 1'b1, 1'b0, -1, 1'b0);
    run_frame(8'd32, 8'd64, 1'b0, 1'b1, -1, 1'b0);
    run_frame(8'd64, 8'd16, 1'b1, 1'b1, 2, 1'b0);  // corrupt sync word
    run_frame(8'd7, 8'd32, 1'b0, 1'b0, -1, 1'b1);
    $display("NO ERRORS");
    $finish;
  end

endmodule
